/* cacheController.sv */
// cacheController: request FSM, miss sequencing, memory handshakes, way commands, response
`timescale 1ns/1ps
`include "cache_macros.svh"

module cacheController import cachePkg::*; (
	input logic clk,
	input logic reset,
	input cpuReq_t cpuReq,
	input logic cpuReqValid,
	output logic cpuReqReady,
	output cpuRsp_t cpuRsp,
	output logic rspValid,
	input logic rspReady,
	output lineAddr_t fillReq,
	output logic fillReqValid,
	input logic fillReqReady,
	input lineData_u fillLine,
	input logic fillValid,
	output wbReq_t wbReq,
	output logic wbValid,
	input logic wbReady,
	input lineAddr_t invAddr,
	input logic invValid,
	output logic invReady,
	output wayCmd_t wayCmd,
	input logic hit,
	input logic [WAY_SEL_W-1:0] hitWay,
	input logic [`WORD_W-1:0] readWord,
	input logic [WAY_SEL_W-1:0] victimWay,
	input logic victimDirty,
	input lineData_u victimLine,
	input logic [`TAG_W-1:0] victimTag
);

	typedef enum logic [2:0] {
		stIdle,
		stLookup,
		stWriteback,
		stFillRequest,
		stFillWait,
		stComplete,
		stRespond
	} state_t;

	state_t state;
	cpuReq_t reqReg;
	cpuRsp_t rspReg;
	wbReq_t wbReg;
	logic [WAY_SEL_W-1:0] victimWayReg;
	logic reqFire;
	logic invFire;

	assign invReady = (state == stIdle);
	assign cpuReqReady = (state == stIdle) && !invValid; // snoops go first
	assign reqFire = cpuReqValid && cpuReqReady;
	assign invFire = invValid && invReady;

	assign cpuRsp = rspReg;
	assign wbReq = wbReg;
	assign fillReq.tag = reqReg.addr.tag;
	assign fillReq.index = reqReg.addr.index;

	always_comb begin
		wayCmd.way = hitWay;
		wayCmd.op = opNone;
		wayCmd.index = reqReg.addr.index;
		wayCmd.tag = reqReg.addr.tag;
		wayCmd.wordSel = reqReg.addr.offset[`OFFSET_W-1 -: WORD_SEL_W];
		wayCmd.wrWord = reqReg.data;
		wayCmd.fillLine = fillLine;
		case (state)
			stIdle: begin
				if (invValid) begin
					wayCmd.index = invAddr.index;
					wayCmd.tag = invAddr.tag;
					if (invFire)
						wayCmd.op = opInvalidate;
				end else begin
					// lookup runs in the accept cycle
					wayCmd.index = cpuReq.addr.index;
					wayCmd.tag = cpuReq.addr.tag;
					wayCmd.wordSel = cpuReq.addr.offset[`OFFSET_W-1 -: WORD_SEL_W];
					wayCmd.wrWord = cpuReq.data;
					if (reqFire && hit)
						wayCmd.op = cpuReq.write ? opWriteWord : opTouch;
				end
			end
			stFillWait: begin
				wayCmd.way = victimWayReg;
				if (fillValid)
					wayCmd.op = opFill;
			end
			stComplete: wayCmd.op = reqReg.write ? opWriteWord : opTouch; // now a hit
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stIdle;
			rspValid <= 1'b0;
			fillReqValid <= 1'b0;
			wbValid <= 1'b0;
		end else begin
			case (state)
				stIdle: begin
					if (reqFire && hit) begin
						rspValid <= 1'b1;
						state <= stRespond;
					end else if (reqFire) begin
						state <= stLookup;
					end
				end
				stLookup: begin
					if (victimDirty) begin
						wbValid <= 1'b1;
						state <= stWriteback;
					end else begin
						fillReqValid <= 1'b1;
						state <= stFillRequest;
					end
				end
				stWriteback: begin
					if (wbReady) begin
						wbValid <= 1'b0;
						fillReqValid <= 1'b1;
						state <= stFillRequest;
					end
				end
				stFillRequest: begin
					if (fillReqReady) begin
						fillReqValid <= 1'b0;
						state <= stFillWait;
					end
				end
				stFillWait: if (fillValid) state <= stComplete;
				stComplete: begin
					rspValid <= 1'b1;
					state <= stRespond;
				end
				stRespond: begin
					if (rspReady) begin
						rspValid <= 1'b0;
						state <= stIdle;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reqFire)
			reqReg <= cpuReq;
		if (state == stLookup) begin
			victimWayReg <= victimWay;
			wbReg.addr.tag <= victimTag;
			wbReg.addr.index <= reqReg.addr.index;
			wbReg.line <= victimLine;
		end
		if ((reqFire && hit) || state == stComplete)
			rspReg.data <= readWord; // don't care on writes
	end

	assert property (@(posedge clk) disable iff (reset)
		(fillReqValid && !fillReqReady) |=> (fillReqValid && $stable(fillReq)))
		else $error("fill request dropped before handshake");

endmodule

/* cachePkg.sv */
// cachePkg: address fields, line union, request/response, memory and way structs
`include "cache_macros.svh"

package cachePkg;

	localparam int WORD_SEL_W = $clog2(`WORDS_PER_LINE);
	localparam int WAY_SEL_W = (`WAY_COUNT > 1) ? $clog2(`WAY_COUNT) : 1;

	typedef struct packed {
		logic [`TAG_W-1:0] tag;
		logic [`INDEX_W-1:0] index;
		logic [`OFFSET_W-1:0] offset; // byte offset in line
	} addrFields_t;

	// memory moves the flat word, the ways pick single words
	typedef union packed {
		logic [`WORDS_PER_LINE*`WORD_W-1:0] flat;
		logic [`WORDS_PER_LINE-1:0][`WORD_W-1:0] words;
	} lineData_u;

	typedef struct packed {
		logic write;
		addrFields_t addr;
		logic [`WORD_W-1:0] data;
	} cpuReq_t;

	typedef struct packed {
		logic [`WORD_W-1:0] data;
	} cpuRsp_t;

	typedef struct packed {
		logic [`TAG_W-1:0] tag;
		logic [`INDEX_W-1:0] index;
	} lineAddr_t;

	typedef struct packed {
		lineAddr_t addr;
		lineData_u line;
	} wbReq_t;

	typedef enum logic [2:0] {
		opNone,
		opTouch,
		opWriteWord,
		opFill,
		opInvalidate
	} wayOp_t;

	typedef struct packed {
		logic [WAY_SEL_W-1:0] way;
		wayOp_t op;
		logic [`INDEX_W-1:0] index;
		logic [`TAG_W-1:0] tag;
		logic [WORD_SEL_W-1:0] wordSel;
		logic [`WORD_W-1:0] wrWord;
		lineData_u fillLine;
	} wayCmd_t;

	typedef struct packed {
		logic tagMatch;
		logic valid;
		logic dirty;
		logic recent; // set when another way was used after this one
		logic [`TAG_W-1:0] tag;
		lineData_u line;
	} wayStatus_t;

endpackage

/* cacheTop.sv */
// cacheTop: controller, generated ways and way merge of the set-associative cache
`timescale 1ns/1ps
`include "cache_macros.svh"

module cacheTop import cachePkg::*; (
	input logic clk,
	input logic reset,
	input cpuReq_t cpuReq,
	input logic cpuReqValid,
	output logic cpuReqReady,
	output cpuRsp_t cpuRsp,
	output logic rspValid,
	input logic rspReady,
	output lineAddr_t fillReq,
	output logic fillReqValid,
	input logic fillReqReady,
	input lineData_u fillLine,
	input logic fillValid,
	output wbReq_t wbReq,
	output logic wbValid,
	input logic wbReady,
	input lineAddr_t invAddr,
	input logic invValid,
	output logic invReady
);

	wayCmd_t wayCmd;
	wayStatus_t wayStatus [`WAY_COUNT];
	logic hit;
	logic [WAY_SEL_W-1:0] hitWay;
	logic [`WORD_W-1:0] readWord;
	logic [WAY_SEL_W-1:0] victimWay;
	logic victimDirty;
	lineData_u victimLine;
	logic [`TAG_W-1:0] victimTag;

	cacheController i_controller (
		.clk(clk),
		.reset(reset),
		.cpuReq(cpuReq),
		.cpuReqValid(cpuReqValid),
		.cpuReqReady(cpuReqReady),
		.cpuRsp(cpuRsp),
		.rspValid(rspValid),
		.rspReady(rspReady),
		.fillReq(fillReq),
		.fillReqValid(fillReqValid),
		.fillReqReady(fillReqReady),
		.fillLine(fillLine),
		.fillValid(fillValid),
		.wbReq(wbReq),
		.wbValid(wbValid),
		.wbReady(wbReady),
		.invAddr(invAddr),
		.invValid(invValid),
		.invReady(invReady),
		.wayCmd(wayCmd),
		.hit(hit),
		.hitWay(hitWay),
		.readWord(readWord),
		.victimWay(victimWay),
		.victimDirty(victimDirty),
		.victimLine(victimLine),
		.victimTag(victimTag)
	);

	// every way sees the same command, wayId picks the target
	for (genvar w = 0; w < `WAY_COUNT; w++) begin : gWay
		cacheWay #(.wayId(w)) i_way (
			.clk(clk),
			.reset(reset),
			.wayCmd(wayCmd),
			.status(wayStatus[w])
		);
	end

	wayMerge i_merge (
		.clk(clk),
		.reset(reset),
		.wayStatus(wayStatus),
		.wordSel(wayCmd.wordSel),
		.hit(hit),
		.hitWay(hitWay),
		.readWord(readWord),
		.victimWay(victimWay),
		.victimDirty(victimDirty),
		.victimLine(victimLine),
		.victimTag(victimTag)
	);

endmodule

/* cacheWay.sv */
// cacheWay: tag, flag and line storage of one way, command decode and status lookup
`timescale 1ns/1ps
`include "cache_macros.svh"

module cacheWay import cachePkg::*; #(
	parameter int wayId = 0
) (
	input logic clk,
	input logic reset,
	input wayCmd_t wayCmd,
	output wayStatus_t status
);

	logic [`TAG_W-1:0] tagMem [`SET_COUNT];
	lineData_u lineMem [`SET_COUNT];
	logic [`SET_COUNT-1:0] validBits;
	logic [`SET_COUNT-1:0] dirtyBits;
	logic [`SET_COUNT-1:0] recentBits;
	logic isTarget;
	logic usesLine;

	assign isTarget = (wayCmd.way == WAY_SEL_W'(wayId));
	// accesses that move the lru marking
	assign usesLine = (wayCmd.op == opTouch) || (wayCmd.op == opWriteWord) ||
		(wayCmd.op == opFill);

	always_comb begin
		status.tagMatch = (tagMem[wayCmd.index] == wayCmd.tag);
		status.valid = validBits[wayCmd.index];
		status.dirty = dirtyBits[wayCmd.index];
		status.recent = recentBits[wayCmd.index];
		status.tag = tagMem[wayCmd.index];
		status.line = lineMem[wayCmd.index];
	end

	always_ff @(posedge clk) begin
		if (isTarget && wayCmd.op == opFill) begin
			tagMem[wayCmd.index] <= wayCmd.tag;
			lineMem[wayCmd.index] <= wayCmd.fillLine;
		end else if (isTarget && wayCmd.op == opWriteWord) begin
			lineMem[wayCmd.index].words[wayCmd.wordSel] <= wayCmd.wrWord;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			validBits <= '0;
			dirtyBits <= '0;
			recentBits <= '0;
		end else begin
			if (isTarget) begin
				case (wayCmd.op)
					opFill: begin
						validBits[wayCmd.index] <= 1'b1;
						dirtyBits[wayCmd.index] <= 1'b0;
					end
					opWriteWord: dirtyBits[wayCmd.index] <= 1'b1;
					opInvalidate: begin
						if (status.tagMatch) // other lines of the set stay
							validBits[wayCmd.index] <= 1'b0;
					end
					default: ;
				endcase
			end
			if (usesLine)
				recentBits[wayCmd.index] <= !isTarget;
		end
	end

	// word writes only land on a resident line
	assert property (@(posedge clk) disable iff (reset)
		(isTarget && wayCmd.op == opWriteWord) |-> (status.valid && status.tagMatch))
		else $error("word write to set %0d without a resident line", wayCmd.index);

endmodule

/* cache_macros.svh */
// cache geometry macros: address, word and line widths, set and way counts
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

`define ADDR_W 32
`define WORD_W 32

`define WORDS_PER_LINE 8
`define SET_COUNT 16
`define WAY_COUNT 2

// derived address fields, tag + index + byte offset = ADDR_W
`define INDEX_W 4
`define OFFSET_W 5
`define TAG_W 23

`endif

/* runSim.sh */
#!/bin/sh
# builds the cache testbench with Verilator and runs it, result taken from the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module tbCacheTop -f sources.f -o simv
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
runStatus=$?
cat sim.log

if grep -q "sim failed" sim.log; then
	echo "simulation reported failure"
	exit 1
fi

if [ $runStatus -ne 0 ]; then
	echo "simulation exited with status $runStatus"
	exit 1
fi

exit 0

/* sources.f */
+incdir+.
cachePkg.sv
cacheWay.sv
wayMerge.sv
cacheController.sv
cacheTop.sv
tbMemory.sv
tbCacheTop.sv

/* tbCacheTop.sv */
// tbCacheTop: clock, reset, stimulus, cache reference model, compare tasks and watchdog
`timescale 1ns/1ps
`include "cache_macros.svh"

module tbCacheTop import cachePkg::*; ();

	localparam int CLK_PERIOD = 20;
	localparam int DRIVE_DELAY = 2;
	localparam int RANDOM_OPS = 400;
	localparam int CYCLE_BUDGET = 100 + (RANDOM_OPS + 12) * 60; // ~60 cycles per access

	typedef struct packed {
		logic isRead;
		cpuRsp_t rsp;
		logic doWb;
		wbReq_t wb;
		logic doFill;
		lineAddr_t fill;
	} prediction_t;

	logic clk;
	logic reset;
	cpuReq_t cpuReq;
	logic cpuReqValid;
	logic cpuReqReady;
	cpuRsp_t cpuRsp;
	logic rspValid;
	logic rspReady;
	lineAddr_t fillReq;
	logic fillReqValid;
	logic fillReqReady;
	lineData_u fillLine;
	logic fillValid;
	wbReq_t wbReq;
	logic wbValid;
	logic wbReady;
	lineAddr_t invAddr;
	logic invValid;
	logic invReady;
	logic memWrValid;
	lineAddr_t memWrAddr;
	lineData_u memWrLine;

	integer seed = 38900;
	int fillCount;
	int wbCount;
	prediction_t rspQ [$];
	wbReq_t wbQ [$];
	lineAddr_t fillQ [$];
	prediction_t accExp;
	prediction_t rspExp;

	// model state, tags used by the tests stay below 4
	logic [`TAG_W-1:0] mTag [`WAY_COUNT][`SET_COUNT];
	logic mValid [`WAY_COUNT][`SET_COUNT];
	logic mDirty [`WAY_COUNT][`SET_COUNT];
	logic mRecent [`WAY_COUNT][`SET_COUNT];
	lineData_u shadow [64]; // architectural line values

	cacheTop i_dut (
		.clk(clk),
		.reset(reset),
		.cpuReq(cpuReq),
		.cpuReqValid(cpuReqValid),
		.cpuReqReady(cpuReqReady),
		.cpuRsp(cpuRsp),
		.rspValid(rspValid),
		.rspReady(rspReady),
		.fillReq(fillReq),
		.fillReqValid(fillReqValid),
		.fillReqReady(fillReqReady),
		.fillLine(fillLine),
		.fillValid(fillValid),
		.wbReq(wbReq),
		.wbValid(wbValid),
		.wbReady(wbReady),
		.invAddr(invAddr),
		.invValid(invValid),
		.invReady(invReady)
	);

	tbMemory i_mem (
		.clk(clk),
		.fillReq(fillReq),
		.fillReqValid(fillReqValid),
		.fillReqReady(fillReqReady),
		.fillLine(fillLine),
		.fillValid(fillValid),
		.wbReq(wbReq),
		.wbValid(wbValid),
		.wbReady(wbReady),
		.memWrValid(memWrValid),
		.memWrAddr(memWrAddr),
		.memWrLine(memWrLine)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic stopOnError(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic checkRsp(input cpuRsp_t got, input cpuRsp_t exp);
		if (got !== exp)
			stopOnError($sformatf("MISMATCH t=%0t cpuRsp got %h expected %h", $time, got, exp));
	endtask

	task automatic checkWb(input wbReq_t got, input wbReq_t exp);
		if (got !== exp)
			stopOnError($sformatf("MISMATCH t=%0t wbReq got %h expected %h", $time, got, exp));
	endtask

	task automatic checkFill(input lineAddr_t got, input lineAddr_t exp);
		if (got !== exp)
			stopOnError($sformatf("MISMATCH t=%0t fillReq got %h expected %h", $time, got, exp));
	endtask

	function automatic logic [5:0] lineKey(input lineAddr_t a);
		return {a.tag[1:0], a.index};
	endfunction

	function automatic logic [`WORD_W-1:0] patternWord(input lineAddr_t la, input int w);
		return {la, 3'(w), 2'b00} ^ 32'h3c5a96e1; // byte address of the word, scrambled
	endfunction

	// reference: predicts traffic and read data, then updates the model
	function automatic prediction_t modelAccess(input cpuReq_t req);
		prediction_t e;
		lineAddr_t la;
		int hitW;
		int v;
		int word;
		e = '0;
		la.tag = req.addr.tag;
		la.index = req.addr.index;
		word = int'(req.addr.offset[`OFFSET_W-1:2]);
		e.isRead = !req.write;
		hitW = -1;
		for (int w = 0; w < `WAY_COUNT; w++)
			if (mValid[w][la.index] && mTag[w][la.index] == la.tag)
				hitW = w;
		if (hitW < 0) begin
			v = -1;
			for (int w = 0; w < `WAY_COUNT; w++)
				if (v < 0 && !mValid[w][la.index])
					v = w;
			for (int w = 0; w < `WAY_COUNT; w++)
				if (v < 0 && mRecent[w][la.index])
					v = w;
			if (v < 0)
				v = 0;
			if (mValid[v][la.index] && mDirty[v][la.index]) begin
				e.doWb = 1'b1;
				e.wb.addr.tag = mTag[v][la.index];
				e.wb.addr.index = la.index;
				e.wb.line = shadow[lineKey(e.wb.addr)];
			end
			e.doFill = 1'b1;
			e.fill = la;
			mTag[v][la.index] = la.tag;
			mValid[v][la.index] = 1'b1;
			mDirty[v][la.index] = 1'b0;
			hitW = v;
		end
		e.rsp.data = shadow[lineKey(la)].words[word];
		if (req.write) begin
			shadow[lineKey(la)].words[word] = req.data;
			mDirty[hitW][la.index] = 1'b1;
		end
		for (int w = 0; w < `WAY_COUNT; w++)
			mRecent[w][la.index] = (w != hitW);
		return e;
	endfunction

	function automatic void modelInvalidate(input lineAddr_t la);
		for (int w = 0; w < `WAY_COUNT; w++)
			if (mValid[w][la.index] && mTag[w][la.index] == la.tag)
				mValid[w][la.index] = 1'b0;
	endfunction

	// compare process, everything sampled at the rising edge
	always @(posedge clk) begin
		if (reset) begin
			fillCount = 0;
			wbCount = 0;
			for (int w = 0; w < `WAY_COUNT; w++)
				for (int i = 0; i < `SET_COUNT; i++) begin
					mTag[w][i] = '0;
					mValid[w][i] = 1'b0;
					mDirty[w][i] = 1'b0;
					mRecent[w][i] = 1'b0;
				end
		end else begin
			if (memWrValid)
				shadow[lineKey(memWrAddr)] = memWrLine;
			if (invValid && invReady)
				modelInvalidate(invAddr);
			if (cpuReqValid && cpuReqReady) begin
				accExp = modelAccess(cpuReq);
				rspQ.push_back(accExp);
				if (accExp.doWb)
					wbQ.push_back(accExp.wb);
				if (accExp.doFill)
					fillQ.push_back(accExp.fill);
			end
			if (wbValid && wbReady) begin
				wbCount++;
				if (wbQ.size() == 0)
					stopOnError("writeback seen where the model predicts none");
				else
					checkWb(wbReq, wbQ.pop_front());
			end
			if (fillReqValid && fillReqReady) begin
				fillCount++;
				if (fillQ.size() == 0)
					stopOnError("fill request seen where the model predicts none");
				else
					checkFill(fillReq, fillQ.pop_front());
			end
			if (rspValid && rspReady) begin
				if (rspQ.size() == 0) begin
					stopOnError("response without an accepted request");
				end else begin
					rspExp = rspQ.pop_front();
					if (wbQ.size() != 0 || fillQ.size() != 0)
						stopOnError("response came before the predicted memory traffic");
					else if (rspExp.isRead)
						checkRsp(cpuRsp, rspExp.rsp);
				end
			end
		end
	end

	task automatic access(input logic write, input lineAddr_t la, input int word,
			input logic [`WORD_W-1:0] data, input logic randomReady, output int waitCycles);
		logic accepted;
		logic done;
		cpuReq.write = write;
		cpuReq.addr.tag = la.tag;
		cpuReq.addr.index = la.index;
		cpuReq.addr.offset = {3'(word), 2'b00};
		cpuReq.data = data;
		cpuReqValid = 1'b1;
		accepted = 1'b0;
		while (!accepted) begin
			@(posedge clk);
			accepted = cpuReqReady;
		end
		#(DRIVE_DELAY);
		cpuReqValid = 1'b0;
		waitCycles = 0;
		done = 1'b0;
		while (!done) begin
			rspReady = randomReady ? 1'($random(seed)) : 1'b1;
			@(posedge clk);
			waitCycles++;
			done = rspValid && rspReady;
			#(DRIVE_DELAY);
		end
		rspReady = 1'b0;
	endtask

	task automatic invalidate(input lineAddr_t la);
		logic accepted;
		invAddr = la;
		invValid = 1'b1;
		accepted = 1'b0;
		while (!accepted) begin
			@(posedge clk);
			accepted = invReady;
		end
		#(DRIVE_DELAY);
		invValid = 1'b0;
	endtask

	task automatic writeBacking(input lineAddr_t la, input lineData_u line);
		memWrAddr = la;
		memWrLine = line;
		memWrValid = 1'b1;
		@(posedge clk);
		#(DRIVE_DELAY);
		memWrValid = 1'b0;
	endtask

	initial begin
		#(CYCLE_BUDGET * CLK_PERIOD);
		stopOnError("timeout, the tests did not finish in time");
	end

	initial begin
		int lat;
		int fillsBefore;
		int wbsBefore;
		lineAddr_t la;
		lineData_u line;
		reset = 1'b1;
		cpuReq = '0;
		cpuReqValid = 1'b0;
		rspReady = 1'b0;
		invAddr = '0;
		invValid = 1'b0;
		memWrValid = 1'b0;
		memWrAddr = '0;
		memWrLine = '0;
		repeat (5) @(posedge clk);
		#(DRIVE_DELAY);
		reset = 1'b0;
		if (rspValid || fillReqValid || wbValid)
			stopOnError("a valid output was high after reset");
		if (!cpuReqReady)
			stopOnError("cpuReqReady was low after reset");

		for (int t = 0; t < 4; t++)
			for (int i = 0; i < `SET_COUNT; i++) begin
				la.tag = `TAG_W'(t);
				la.index = `INDEX_W'(i);
				for (int w = 0; w < `WORDS_PER_LINE; w++)
					line.words[w] = patternWord(la, w);
				writeBacking(la, line);
			end

		// read miss then read hit
		la.tag = `TAG_W'(1);
		la.index = `INDEX_W'(8);
		fillsBefore = fillCount;
		access(1'b0, la, 3, '0, 1'b0, lat);
		access(1'b0, la, 3, '0, 1'b0, lat);
		if (lat != 1)
			stopOnError($sformatf("read hit answered after %0d cycles instead of 1", lat));
		if (fillCount != fillsBefore + 1)
			stopOnError("read miss and hit did not give exactly one fill request");

		// write hit then read back
		fillsBefore = fillCount;
		wbsBefore = wbCount;
		access(1'b1, la, 5, 32'hc0ffee01, 1'b0, lat);
		access(1'b0, la, 5, '0, 1'b0, lat);
		if (fillCount != fillsBefore || wbCount != wbsBefore)
			stopOnError("write hit and read back caused memory traffic");

		// three dirty lines on one index force an lru eviction
		wbsBefore = wbCount;
		for (int t = 0; t < 3; t++) begin
			la.tag = `TAG_W'(t);
			la.index = `INDEX_W'(6);
			access(1'b1, la, t, 32'h1000 + t, 1'b0, lat);
		end
		if (wbCount != wbsBefore + 1)
			stopOnError("third line on one index did not write back the LRU way");

		// invalidate a clean line after memory changed under it
		la.tag = `TAG_W'(2);
		la.index = `INDEX_W'(9);
		access(1'b0, la, 1, '0, 1'b0, lat);
		for (int w = 0; w < `WORDS_PER_LINE; w++)
			line.words[w] = ~patternWord(la, w);
		writeBacking(la, line);
		invalidate(la);
		fillsBefore = fillCount;
		access(1'b0, la, 1, '0, 1'b0, lat);
		if (fillCount != fillsBefore + 1)
			stopOnError("read after invalidation did not refill the line");

		for (int n = 0; n < RANDOM_OPS; n++) begin
			la.tag = `TAG_W'($random(seed) & 3);
			la.index = `INDEX_W'($random(seed) & 3);
			access(1'($random(seed)), la, $random(seed) & 7, $random(seed), 1'b1, lat);
		end

		if (rspQ.size() != 0 || wbQ.size() != 0 || fillQ.size() != 0) begin
			stopOnError("predicted responses or memory traffic still outstanding at the end");
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

/* tbMemory.sv */
// tbMemory: backing store model answering fills with random latency and taking writebacks
`timescale 1ns/1ps
`include "cache_macros.svh"

module tbMemory import cachePkg::*; (
	input logic clk,
	input lineAddr_t fillReq,
	input logic fillReqValid,
	output logic fillReqReady,
	output lineData_u fillLine,
	output logic fillValid,
	input wbReq_t wbReq,
	input logic wbValid,
	output logic wbReady,
	input logic memWrValid, // direct store write from the testbench
	input lineAddr_t memWrAddr,
	input lineData_u memWrLine
);

	lineData_u store [lineAddr_t];
	integer seed = 38900;
	logic pending;
	lineAddr_t pendAddr;
	int delay;

	initial begin
		fillReqReady = 1'b0;
		fillLine = '0;
		fillValid = 1'b0;
		wbReady = 1'b0;
		pending = 1'b0;
		pendAddr = '0;
		delay = 0;
		forever begin
			@(posedge clk);
			if (memWrValid)
				store[memWrAddr] = memWrLine;
			if (wbValid && wbReady)
				store[wbReq.addr] = wbReq.line;
			if (fillReqValid && fillReqReady) begin
				pending = 1'b1;
				pendAddr = fillReq;
				delay = $random(seed) & 3; // 0..3 extra cycles
			end
			#2;
			fillValid = 1'b0;
			if (pending && delay == 0) begin
				fillLine = store.exists(pendAddr) ? store[pendAddr] : '0;
				fillValid = 1'b1;
				pending = 1'b0;
			end else if (pending) begin
				delay = delay - 1;
			end
			fillReqReady = 1'($random(seed));
			wbReady = 1'($random(seed));
		end
	end

endmodule

/* wayMerge.sv */
// wayMerge: hit detection, read word select and victim choice over all way statuses
`timescale 1ns/1ps
`include "cache_macros.svh"

module wayMerge import cachePkg::*; (
	input logic clk,
	input logic reset,
	input wayStatus_t wayStatus [`WAY_COUNT],
	input logic [WORD_SEL_W-1:0] wordSel,
	output logic hit,
	output logic [WAY_SEL_W-1:0] hitWay,
	output logic [`WORD_W-1:0] readWord,
	output logic [WAY_SEL_W-1:0] victimWay,
	output logic victimDirty,
	output lineData_u victimLine,
	output logic [`TAG_W-1:0] victimTag
);

	logic [`WAY_COUNT-1:0] hitVec;

	always_comb begin
		hit = 1'b0;
		hitWay = '0;
		for (int w = 0; w < `WAY_COUNT; w++) begin
			hitVec[w] = wayStatus[w].valid && wayStatus[w].tagMatch;
			if (hitVec[w]) begin
				hit = 1'b1;
				hitWay = WAY_SEL_W'(w);
			end
		end
		readWord = wayStatus[hitWay].line.words[wordSel];
	end

	// downward loops so the lowest way wins
	always_comb begin
		victimWay = '0;
		for (int w = `WAY_COUNT - 1; w >= 0; w--) begin
			if (wayStatus[w].recent)
				victimWay = WAY_SEL_W'(w);
		end
		for (int w = `WAY_COUNT - 1; w >= 0; w--) begin
			if (!wayStatus[w].valid) // free way beats lru
				victimWay = WAY_SEL_W'(w);
		end
		victimDirty = wayStatus[victimWay].valid && wayStatus[victimWay].dirty;
		victimLine = wayStatus[victimWay].line;
		victimTag = wayStatus[victimWay].tag;
	end

	assert property (@(posedge clk) disable iff (reset) $onehot0(hitVec))
		else $error("line resident in more than one way: %b", hitVec);

endmodule
